// ==== files.f ====
hdl/ossc_pkg.sv
hdl/capture_select.sv
hdl/osd_overlay.sv
hdl/panel_status.sv
hdl/ossc_core.sv
verification/ossc_core_asserts.sv
verification/ossc_core_tb.sv

// ==== verification/ossc_core_tb.sv ====
// Directed testbench for ossc_core with a short LED hold time.
// Inputs change 2 units after the rising edge, outputs are read at that point.
// Expects R_LSB_CLEAR set, so red bit 0 is always zero on the HDMITX pins.

module ossc_core_tb;

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DLY   = 2;
    localparam int HOLD_CYCLES = 20;
    localparam bit R_LSB_CLEAR = 1'b1;
    localparam int PIX_W       = 3 * ossc_pkg::COLOR_W + 3;
    localparam int N_PIX       = 32;
    localparam int N_BTN       = 8;

    // cycle budget per test, used by the watchdog
    localparam int STREAM_CYCLES   = N_PIX + 4;
    localparam int TOTAL_CYCLES    = 4 + 6 * STREAM_CYCLES + (4 + 3 * N_BTN)
                                     + (HOLD_CYCLES + 16);
    localparam int WATCHDOG_CYCLES = 2 * TOTAL_CYCLES + 100;

    logic                         CLK27_i;
    logic                         po_reset_n;
    logic                         capture_sel_i;
    logic                         sys_poweron_i;
    logic                         adap_lm_i;
    logic                         osd_enable_i;
    ossc_pkg::osd_color_t         osd_color_i;
    logic                         resync_strobe_i;
    logic [ossc_pkg::BTN_W-1:0]   BTN_i;
    logic [ossc_pkg::COLOR_W-1:0] isl_r_i;
    logic [ossc_pkg::COLOR_W-1:0] isl_g_i;
    logic [ossc_pkg::COLOR_W-1:0] isl_b_i;
    logic                         isl_hsync_i;
    logic                         isl_vsync_i;
    logic                         isl_de_i;
    logic [ossc_pkg::COLOR_W-1:0] hdmirx_r_i;
    logic [ossc_pkg::COLOR_W-1:0] hdmirx_g_i;
    logic [ossc_pkg::COLOR_W-1:0] hdmirx_b_i;
    logic                         hdmirx_hsync_i;
    logic                         hdmirx_vsync_i;
    logic                         hdmirx_de_i;
    logic [ossc_pkg::COLOR_W-1:0] HDMITX_R_o;
    logic [ossc_pkg::COLOR_W-1:0] HDMITX_G_o;
    logic [ossc_pkg::COLOR_W-1:0] HDMITX_B_o;
    logic                         HDMITX_HSYNC_o;
    logic                         HDMITX_VSYNC_o;
    logic                         HDMITX_DE_o;
    logic [ossc_pkg::BTN_W-1:0]   btn_sync_o;
    logic [ossc_pkg::LED_W-1:0]   LED_o;

    int check_cnt;
    int err_cnt;
    int total_errors;

    ossc_core #(
        .LED_HOLD_CYCLES (HOLD_CYCLES),
        .R_LSB_CLEAR     (R_LSB_CLEAR)
    ) ossc_core_i (.*);

    initial begin
        CLK27_i = 1'b0;
        forever #(CLK_PERIOD / 2) CLK27_i = ~CLK27_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic compare_value(input string test_name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("[FAIL] %s expected %0h actual %0h", test_name, expected, actual);
        end
    endtask

    task automatic apply_reset();
        po_reset_n = 1'b0;
        repeat (3) @(posedge CLK27_i);
        #DRIVE_DLY;
        po_reset_n = 1'b1;
    endtask

    // drives random pixels on both sources and checks each one 3 cycles later
    task automatic run_stream(input string test_name, input logic sel, input logic osd_en,
                              input ossc_pkg::osd_color_t color,
                              input logic [3*ossc_pkg::COLOR_W-1:0] osd_rgb,
                              input int n_pix);
        logic [PIX_W-1:0]                 exp_q[$];
        logic [PIX_W-1:0]                 exp_word;
        logic [3*ossc_pkg::COLOR_W-1:0]   exp_rgb;
        logic [2:0]                       exp_sync;
        for (int step = 0; step < n_pix + 3; step++) begin
            @(posedge CLK27_i);
            #DRIVE_DLY;
            if (step >= 3) begin
                exp_word = exp_q.pop_front();
                compare_value(test_name, 32'(exp_word),
                              32'({HDMITX_R_o, HDMITX_G_o, HDMITX_B_o,
                                   HDMITX_HSYNC_o, HDMITX_VSYNC_o, HDMITX_DE_o}));
            end
            if (step < n_pix) begin
                capture_sel_i  = sel;
                osd_enable_i   = osd_en;
                osd_color_i    = color;
                isl_r_i        = 8'($urandom);
                isl_g_i        = 8'($urandom);
                isl_b_i        = 8'($urandom);
                isl_hsync_i    = 1'($urandom);
                isl_vsync_i    = 1'($urandom);
                isl_de_i       = 1'($urandom);
                hdmirx_r_i     = 8'($urandom);
                hdmirx_g_i     = 8'($urandom);
                hdmirx_b_i     = 8'($urandom);
                hdmirx_hsync_i = 1'($urandom);
                hdmirx_vsync_i = 1'($urandom);
                hdmirx_de_i    = 1'($urandom);
                if (sel) begin
                    exp_rgb  = {hdmirx_r_i, hdmirx_g_i, hdmirx_b_i};
                    exp_sync = {hdmirx_hsync_i, hdmirx_vsync_i, hdmirx_de_i};
                end else begin
                    exp_rgb  = {isl_r_i, isl_g_i, isl_b_i};
                    exp_sync = {isl_hsync_i, isl_vsync_i, isl_de_i};
                end
                if (osd_en) begin
                    exp_rgb = osd_rgb;
                end
                // red bit 0 sits at the bottom of the top byte
                if (R_LSB_CLEAR) begin
                    exp_rgb[2*ossc_pkg::COLOR_W] = 1'b0;
                end
                exp_q.push_back({exp_rgb, exp_sync});
            end
        end
    endtask

    task automatic test_digitizer_path();
        run_stream("digitizer_path", 1'b0, 1'b0, ossc_pkg::OSD_BLACK,
                   ossc_pkg::OSD_RGB_BLACK, N_PIX);
    endtask

    task automatic test_receiver_path();
        run_stream("receiver_path", 1'b1, 1'b0, ossc_pkg::OSD_BLACK,
                   ossc_pkg::OSD_RGB_BLACK, N_PIX);
    endtask

    // one palette colour per run, alternating the source underneath
    task automatic test_osd_palette();
        run_stream("osd_palette", 1'b0, 1'b1, ossc_pkg::OSD_BLACK,
                   ossc_pkg::OSD_RGB_BLACK, N_PIX);
        run_stream("osd_palette", 1'b1, 1'b1, ossc_pkg::OSD_BLUE,
                   ossc_pkg::OSD_RGB_BLUE, N_PIX);
        run_stream("osd_palette", 1'b0, 1'b1, ossc_pkg::OSD_YELLOW,
                   ossc_pkg::OSD_RGB_YELLOW, N_PIX);
        run_stream("osd_palette", 1'b1, 1'b1, ossc_pkg::OSD_WHITE,
                   ossc_pkg::OSD_RGB_WHITE, N_PIX);
    endtask

    task automatic test_buttons();
        logic [ossc_pkg::BTN_W-1:0] btn_val;
        sys_poweron_i = 1'b1;
        apply_reset();
        compare_value("reset_btn_sync", 32'(6'h3f), 32'(btn_sync_o));
        compare_value("reset_hdmitx_de", 32'(1'b0), 32'(HDMITX_DE_o));
        for (int i = 0; i < N_BTN; i++) begin
            @(posedge CLK27_i);
            #DRIVE_DLY;
            btn_val = (i % 3 == 0) ? '1 : ossc_pkg::BTN_W'($urandom);
            BTN_i   = btn_val;
            repeat (2) @(posedge CLK27_i);
            #DRIVE_DLY;
            compare_value("btn_sync", 32'(btn_val), 32'(btn_sync_o));
            compare_value("led_btn_released", 32'(btn_val == '1), 32'(LED_o[1]));
        end
    endtask

    task automatic test_resync_led();
        logic adap;
        logic hold;
        adap            = 1'b0;
        adap_lm_i       = adap;
        BTN_i           = '1;
        sys_poweron_i   = 1'b1;
        repeat (3) @(posedge CLK27_i);
        #DRIVE_DLY;
        resync_strobe_i = 1'b1;
        // counter loads on the third edge after the strobe rises
        for (int k = 1; k <= HOLD_CYCLES + 6; k++) begin
            @(posedge CLK27_i);
            #DRIVE_DLY;
            hold = (k >= 3) && (k < 3 + HOLD_CYCLES);
            compare_value("resync_led", 32'({adap, 1'b1, hold}), 32'(LED_o));
            if (k == 5) begin
                resync_strobe_i = 1'b0;
            end
            if (k == 10) begin
                adap      = 1'b1;
                adap_lm_i = adap;
            end
        end
        sys_poweron_i = 1'b0;
        for (int k = 0; k < 6; k++) begin
            @(posedge CLK27_i);
            #DRIVE_DLY;
            compare_value("power_off_led", 32'(ossc_pkg::LED_POWEROFF), 32'(LED_o));
            adap_lm_i       = 1'($urandom);
            resync_strobe_i = 1'($urandom);
        end
    endtask

    initial begin
        void'($urandom(32'h2e91));
        check_cnt       = 0;
        err_cnt         = 0;
        po_reset_n      = 1'b0;
        capture_sel_i   = 1'b0;
        sys_poweron_i   = 1'b0;
        adap_lm_i       = 1'b0;
        osd_enable_i    = 1'b0;
        osd_color_i     = ossc_pkg::OSD_BLACK;
        resync_strobe_i = 1'b0;
        BTN_i           = '1;
        isl_r_i         = '0;
        isl_g_i         = '0;
        isl_b_i         = '0;
        isl_hsync_i     = 1'b0;
        isl_vsync_i     = 1'b0;
        isl_de_i        = 1'b0;
        hdmirx_r_i      = '0;
        hdmirx_g_i      = '0;
        hdmirx_b_i      = '0;
        hdmirx_hsync_i  = 1'b0;
        hdmirx_vsync_i  = 1'b0;
        hdmirx_de_i     = 1'b0;
        apply_reset();

        test_digitizer_path();
        test_receiver_path();
        test_osd_palette();
        test_buttons();
        test_resync_led();

        total_errors = err_cnt + ossc_core_i.ossc_core_asserts_i.fail_cnt;
        $display("checks: %0d, check errors: %0d, assertion errors: %0d",
                 check_cnt, err_cnt, ossc_core_i.ossc_core_asserts_i.fail_cnt);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/ossc_core_asserts.sv ====
// Concurrent checks on the ossc_core ports, attached with bind.
// All checks are disabled while po_reset_n is low.
// fail_cnt is read by the testbench for its final verdict.

module ossc_core_asserts (
    input logic                         CLK27_i,
    input logic                         po_reset_n,
    input logic                         sys_poweron_i,
    input logic [ossc_pkg::LED_W-1:0]   led_i,
    input logic                         hdmitx_de_i,
    input logic                         capt_de_i
);

    int fail_cnt = 0;

    de_known: assert property (@(posedge CLK27_i) disable iff (!po_reset_n)
        !$isunknown(hdmitx_de_i))
    else begin
        fail_cnt++;
        $error("HDMITX_DE_o is unknown after reset");
    end

    led_poweroff: assert property (@(posedge CLK27_i) disable iff (!po_reset_n)
        !sys_poweron_i |-> led_i == ossc_pkg::LED_POWEROFF)
    else begin
        fail_cnt++;
        $error("LED_o differs from the power-off pattern while powered off");
    end

    // overlay and launch registers add two cycles to DE
    de_delay: assert property (@(posedge CLK27_i) disable iff (!po_reset_n)
        hdmitx_de_i == $past(capt_de_i, 2))
    else begin
        fail_cnt++;
        $error("HDMITX_DE_o does not follow capture DE two cycles later");
    end

endmodule

bind ossc_core ossc_core_asserts ossc_core_asserts_i (
    .CLK27_i       (CLK27_i),
    .po_reset_n    (po_reset_n),
    .sys_poweron_i (sys_poweron_i),
    .led_i         (LED_o),
    .hdmitx_de_i   (HDMITX_DE_o),
    .capt_de_i     (capt_de)
);

// ==== hdl/ossc_core.sv ====
// Board-level glue of the video path and front panel, all on CLK27_i.
// Pixel latency from the source pins to the HDMITX pins is fixed at 3 cycles.
// OSD enable and colour lead the HDMITX pins by 2 cycles, capture_sel_i by 3.

module ossc_core #(
    parameter int unsigned LED_HOLD_CYCLES = 32'd16777215,
    parameter bit          R_LSB_CLEAR     = 1'b1
) (
    input  logic                         CLK27_i,
    input  logic                         po_reset_n,

    input  logic                         capture_sel_i,
    input  logic                         sys_poweron_i,
    input  logic                         adap_lm_i,
    input  logic                         osd_enable_i,
    input  ossc_pkg::osd_color_t         osd_color_i,
    input  logic                         resync_strobe_i,
    input  logic [ossc_pkg::BTN_W-1:0]   BTN_i,

    input  logic [ossc_pkg::COLOR_W-1:0] isl_r_i,
    input  logic [ossc_pkg::COLOR_W-1:0] isl_g_i,
    input  logic [ossc_pkg::COLOR_W-1:0] isl_b_i,
    input  logic                         isl_hsync_i,
    input  logic                         isl_vsync_i,
    input  logic                         isl_de_i,

    input  logic [ossc_pkg::COLOR_W-1:0] hdmirx_r_i,
    input  logic [ossc_pkg::COLOR_W-1:0] hdmirx_g_i,
    input  logic [ossc_pkg::COLOR_W-1:0] hdmirx_b_i,
    input  logic                         hdmirx_hsync_i,
    input  logic                         hdmirx_vsync_i,
    input  logic                         hdmirx_de_i,

    output logic [ossc_pkg::COLOR_W-1:0] HDMITX_R_o,
    output logic [ossc_pkg::COLOR_W-1:0] HDMITX_G_o,
    output logic [ossc_pkg::COLOR_W-1:0] HDMITX_B_o,
    output logic                         HDMITX_HSYNC_o,
    output logic                         HDMITX_VSYNC_o,
    output logic                         HDMITX_DE_o,
    output logic [ossc_pkg::BTN_W-1:0]   btn_sync_o,
    output logic [ossc_pkg::LED_W-1:0]   LED_o
);

    logic [ossc_pkg::COLOR_W-1:0] capt_r;
    logic [ossc_pkg::COLOR_W-1:0] capt_g;
    logic [ossc_pkg::COLOR_W-1:0] capt_b;
    logic                         capt_hsync;
    logic                         capt_vsync;
    logic                         capt_de;

    capture_select capture_select_i (
        .CLK27_i        (CLK27_i),
        .po_reset_n     (po_reset_n),
        .capture_sel_i  (capture_sel_i),
        .isl_r_i        (isl_r_i),
        .isl_g_i        (isl_g_i),
        .isl_b_i        (isl_b_i),
        .isl_hsync_i    (isl_hsync_i),
        .isl_vsync_i    (isl_vsync_i),
        .isl_de_i       (isl_de_i),
        .hdmirx_r_i     (hdmirx_r_i),
        .hdmirx_g_i     (hdmirx_g_i),
        .hdmirx_b_i     (hdmirx_b_i),
        .hdmirx_hsync_i (hdmirx_hsync_i),
        .hdmirx_vsync_i (hdmirx_vsync_i),
        .hdmirx_de_i    (hdmirx_de_i),
        .r_o            (capt_r),
        .g_o            (capt_g),
        .b_o            (capt_b),
        .hsync_o        (capt_hsync),
        .vsync_o        (capt_vsync),
        .de_o           (capt_de)
    );

    osd_overlay #(
        .R_LSB_CLEAR (R_LSB_CLEAR)
    ) osd_overlay_i (
        .CLK27_i      (CLK27_i),
        .po_reset_n   (po_reset_n),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .r_i          (capt_r),
        .g_i          (capt_g),
        .b_i          (capt_b),
        .hsync_i      (capt_hsync),
        .vsync_i      (capt_vsync),
        .de_i         (capt_de),
        .r_o          (HDMITX_R_o),
        .g_o          (HDMITX_G_o),
        .b_o          (HDMITX_B_o),
        .hsync_o      (HDMITX_HSYNC_o),
        .vsync_o      (HDMITX_VSYNC_o),
        .de_o         (HDMITX_DE_o)
    );

    panel_status #(
        .LED_HOLD_CYCLES (LED_HOLD_CYCLES)
    ) panel_status_i (
        .CLK27_i         (CLK27_i),
        .po_reset_n      (po_reset_n),
        .btn_i           (BTN_i),
        .resync_strobe_i (resync_strobe_i),
        .sys_poweron_i   (sys_poweron_i),
        .adap_lm_i       (adap_lm_i),
        .btn_sync_o      (btn_sync_o),
        .led_o           (LED_o)
    );

endmodule

// ==== hdl/panel_status.sv ====
// Front-panel button synchronizers, resync LED stretcher and LED pattern.
// Buttons are active low. resync_strobe_i may be fully asynchronous.
// A strobe rising edge keeps LED 0 lit for LED_HOLD_CYCLES clock cycles.

module panel_status #(
    parameter int unsigned LED_HOLD_CYCLES = 32'd16777215
) (
    input  logic                       CLK27_i,
    input  logic                       po_reset_n,
    input  logic [ossc_pkg::BTN_W-1:0] btn_i,
    input  logic                       resync_strobe_i,
    input  logic                       sys_poweron_i,
    input  logic                       adap_lm_i,

    output logic [ossc_pkg::BTN_W-1:0] btn_sync_o,
    output logic [ossc_pkg::LED_W-1:0] led_o
);

    localparam int CNT_W = $clog2(LED_HOLD_CYCLES + 1);

    logic [ossc_pkg::BTN_W-1:0] btn_sync1;
    logic                       strobe_sync1;
    logic                       strobe_sync2;
    logic                       strobe_prev;
    logic                       strobe_rise;
    logic [CNT_W-1:0]           hold_cnt;
    logic                       btn_released;

    // two-flop synchronizers, released state during reset
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            btn_sync1  <= '1;
            btn_sync_o <= '1;
        end else begin
            btn_sync1  <= btn_i;
            btn_sync_o <= btn_sync1;
        end
    end

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            strobe_sync1 <= 1'b0;
            strobe_sync2 <= 1'b0;
            strobe_prev  <= 1'b0;
        end else begin
            strobe_sync1 <= resync_strobe_i;
            strobe_sync2 <= strobe_sync1;
            strobe_prev  <= strobe_sync2;
        end
    end

    assign strobe_rise = strobe_sync2 & ~strobe_prev;

    // a new edge restarts the hold time
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hold_cnt <= '0;
        end else if (strobe_rise) begin
            hold_cnt <= CNT_W'(LED_HOLD_CYCLES);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - CNT_W'(1);
        end
    end

    assign btn_released = &btn_sync_o;

    // bit 2 down to bit 0: limited-range mode, idle buttons, resync seen
    assign led_o = sys_poweron_i ? {adap_lm_i, btn_released, (hold_cnt != '0)}
                                 : ossc_pkg::LED_POWEROFF;

endmodule

// ==== hdl/osd_overlay.sv ====
// OSD colour overlay followed by the HDMI transmitter launch register.
// osd_enable_i and osd_color_i must be aligned with the incoming pixel.
// R_LSB_CLEAR drops red bit 0, a workaround for a board signal-integrity fault.

module osd_overlay #(
    parameter bit R_LSB_CLEAR = 1'b1
) (
    input  logic                         CLK27_i,
    input  logic                         po_reset_n,
    input  logic                         osd_enable_i,
    input  ossc_pkg::osd_color_t         osd_color_i,

    input  logic [ossc_pkg::COLOR_W-1:0] r_i,
    input  logic [ossc_pkg::COLOR_W-1:0] g_i,
    input  logic [ossc_pkg::COLOR_W-1:0] b_i,
    input  logic                         hsync_i,
    input  logic                         vsync_i,
    input  logic                         de_i,

    output logic [ossc_pkg::COLOR_W-1:0] r_o,
    output logic [ossc_pkg::COLOR_W-1:0] g_o,
    output logic [ossc_pkg::COLOR_W-1:0] b_o,
    output logic                         hsync_o,
    output logic                         vsync_o,
    output logic                         de_o
);

    logic [3*ossc_pkg::COLOR_W-1:0] palette_rgb;
    logic [3*ossc_pkg::COLOR_W-1:0] rgb_out;
    logic                           hsync_out;
    logic                           vsync_out;
    logic                           de_out;

    always_comb begin
        case (osd_color_i)
            ossc_pkg::OSD_BLACK:  palette_rgb = ossc_pkg::OSD_RGB_BLACK;
            ossc_pkg::OSD_BLUE:   palette_rgb = ossc_pkg::OSD_RGB_BLUE;
            ossc_pkg::OSD_YELLOW: palette_rgb = ossc_pkg::OSD_RGB_YELLOW;
            default:              palette_rgb = ossc_pkg::OSD_RGB_WHITE;
        endcase
    end

    // overlay stage, sync and DE untouched
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            rgb_out   <= '0;
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
            de_out    <= 1'b0;
        end else begin
            rgb_out   <= osd_enable_i ? palette_rgb : {r_i, g_i, b_i};
            hsync_out <= hsync_i;
            vsync_out <= vsync_i;
            de_out    <= de_i;
        end
    end

    // launch register to the transmitter pins
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            {r_o, g_o, b_o} <= '0;
            hsync_o         <= 1'b0;
            vsync_o         <= 1'b0;
            de_o            <= 1'b0;
        end else begin
            {r_o, g_o, b_o} <= rgb_out;
            if (R_LSB_CLEAR) begin
                r_o[0] <= 1'b0;
            end
            hsync_o <= hsync_out;
            vsync_o <= vsync_out;
            de_o    <= de_out;
        end
    end

endmodule

// ==== hdl/capture_select.sv ====
// Registered selection between the digitizer and HDMI receiver streams.
// Both sources must already be in the CLK27_i domain.
// One register stage; colour, sync and DE switch on the same edge.

module capture_select (
    input  logic                         CLK27_i,
    input  logic                         po_reset_n,
    input  logic                         capture_sel_i,

    input  logic [ossc_pkg::COLOR_W-1:0] isl_r_i,
    input  logic [ossc_pkg::COLOR_W-1:0] isl_g_i,
    input  logic [ossc_pkg::COLOR_W-1:0] isl_b_i,
    input  logic                         isl_hsync_i,
    input  logic                         isl_vsync_i,
    input  logic                         isl_de_i,

    input  logic [ossc_pkg::COLOR_W-1:0] hdmirx_r_i,
    input  logic [ossc_pkg::COLOR_W-1:0] hdmirx_g_i,
    input  logic [ossc_pkg::COLOR_W-1:0] hdmirx_b_i,
    input  logic                         hdmirx_hsync_i,
    input  logic                         hdmirx_vsync_i,
    input  logic                         hdmirx_de_i,

    output logic [ossc_pkg::COLOR_W-1:0] r_o,
    output logic [ossc_pkg::COLOR_W-1:0] g_o,
    output logic [ossc_pkg::COLOR_W-1:0] b_o,
    output logic                         hsync_o,
    output logic                         vsync_o,
    output logic                         de_o
);

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            r_o     <= '0;
            g_o     <= '0;
            b_o     <= '0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            de_o    <= 1'b0;
        end else if (capture_sel_i) begin
            // HDMI receiver
            r_o     <= hdmirx_r_i;
            g_o     <= hdmirx_g_i;
            b_o     <= hdmirx_b_i;
            hsync_o <= hdmirx_hsync_i;
            vsync_o <= hdmirx_vsync_i;
            de_o    <= hdmirx_de_i;
        end else begin
            // analog digitizer
            r_o     <= isl_r_i;
            g_o     <= isl_g_i;
            b_o     <= isl_b_i;
            hsync_o <= isl_hsync_i;
            vsync_o <= isl_vsync_i;
            de_o    <= isl_de_i;
        end
    end

endmodule

// ==== hdl/ossc_pkg.sv ====
// Shared widths, OSD palette and LED patterns for the video glue logic.
// Palette words are packed red-green-blue with red in the top byte.
// Buttons are active low, so an all-ones vector means nothing is pressed.

package ossc_pkg;

    // bits per colour channel on every video bus
    parameter int COLOR_W = 8;

    // front-panel buttons
    parameter int BTN_W = 6;

    // status LEDs, bit 2 down to bit 0 is blue, green, red on the board
    parameter int LED_W = 3;

    // OSD colour index as delivered by the OSD generator
    typedef enum logic [1:0] {
        OSD_BLACK  = 2'h0,
        OSD_BLUE   = 2'h1,
        OSD_YELLOW = 2'h2,
        OSD_WHITE  = 2'h3
    } osd_color_t;

    // palette words, {r, g, b}
    parameter logic [3*COLOR_W-1:0] OSD_RGB_BLACK  = 24'h000000;
    parameter logic [3*COLOR_W-1:0] OSD_RGB_BLUE   = 24'h0000ff;
    parameter logic [3*COLOR_W-1:0] OSD_RGB_YELLOW = 24'hffff00;
    parameter logic [3*COLOR_W-1:0] OSD_RGB_WHITE  = 24'hffffff;

    // only the red LED lit while the system is off
    parameter logic [LED_W-1:0] LED_POWEROFF = 3'b001;

endpackage
